// ==== tb.f ====
icache_pkg.sv
icache_arrays.sv
icache_lookup.sv
icache_compare.sv
icache_refill.sv
icache_flush.sv
icache_top.sv
tb_mem_model.sv
tb_icache.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_icache
FILELIST  := tb.f
OBJ_DIR   := obj_dir

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_icache.sv ====
`timescale 1ns/1ps

module tb_icache;
  import icache_pkg::*;

  localparam int unsigned ClkPeriod      = 40;
  localparam int unsigned ResetCycles    = 3;
  localparam int unsigned NumEntries     = 20;
  localparam int unsigned NumRandom      = 24;
  localparam int unsigned CyclesPerFetch = 400;
  localparam logic [31:0] Seed           = 32'd28179;
  // Reset and the first flush walk count as two more entries
  localparam int unsigned WatchdogCycles = (NumEntries + NumRandom + 2) * CyclesPerFetch;

  typedef struct packed {
    fetch_addr_t addr;
    logic        flush;
    logic        fault;
    logic [3:0]  req_delta;
    logic [3:0]  latency;
  } entry_t;

  logic        clk          = 1'b0;
  logic        rst_n        = 1'b0;
  logic        fetch_valid  = 1'b0;
  fetch_req_t  fetch_req    = '0;
  logic        fetch_ready;
  logic        rsp_valid;
  fetch_rsp_t  fetch_rsp;
  logic        mem_req_valid;
  mem_req_t    mem_req;
  logic        mem_req_credit;
  logic        mem_rsp_valid;
  mem_rsp_t    mem_rsp;
  logic        mem_rsp_credit;
  int unsigned req_count;
  int unsigned rsp_count    = 0;

  // Columns are address, flush, fault, new memory requests and hit latency (0 means unchecked)
  // Set index is address bits 8:5, so the 0x2n60 lines all land in set 3
  entry_t stim [NumEntries] = '{
    '{32'h0000_1004, 1'b0, 1'b0, 4'd1, 4'd0},
    '{32'h0000_1010, 1'b0, 1'b0, 4'd0, 4'd2},
    '{32'h0000_2060, 1'b0, 1'b0, 4'd1, 4'd0},
    '{32'h0000_2264, 1'b0, 1'b0, 4'd1, 4'd0},
    '{32'h0000_2468, 1'b0, 1'b0, 4'd1, 4'd0},
    '{32'h0000_266C, 1'b0, 1'b0, 4'd1, 4'd0},
    '{32'h0000_2870, 1'b0, 1'b0, 4'd1, 4'd0},
    // Pseudo-FIFO victims make every refetch of the five lines miss
    '{32'h0000_207C, 1'b0, 1'b0, 4'd1, 4'd0},
    '{32'h0000_2260, 1'b0, 1'b0, 4'd1, 4'd0},
    '{32'h0000_2460, 1'b0, 1'b0, 4'd1, 4'd0},
    '{32'h0000_2660, 1'b0, 1'b0, 4'd1, 4'd0},
    '{32'h0000_2860, 1'b0, 1'b0, 4'd1, 4'd0},
    '{32'h0000_2464, 1'b0, 1'b0, 4'd0, 4'd2},
    // Denied region where no tag is ever written
    '{32'h0800_0100, 1'b0, 1'b1, 4'd1, 4'd0},
    '{32'h0800_0104, 1'b0, 1'b1, 4'd1, 4'd0},
    // Above the physical address range
    '{32'h1000_1004, 1'b0, 1'b1, 4'd0, 4'd2},
    '{32'h8000_0000, 1'b0, 1'b1, 4'd0, 4'd2},
    // A flush followed by lines cached before it
    '{32'h0000_1008, 1'b1, 1'b0, 4'd1, 4'd0},
    '{32'h0000_2468, 1'b0, 1'b0, 4'd1, 4'd0},
    '{32'h0000_100C, 1'b0, 1'b0, 4'd0, 4'd2}
  };

  always #(ClkPeriod / 2) clk = ~clk;

  icache_top #(
    .WaysWidth   (2),
    .SetsWidth   (4),
    .PhysAddrLen (28),
    .RspCredits  (2)
  ) icache_top_inst (
    .clk_i            (clk),
    .rst_ni           (rst_n),
    .fetch_valid_i    (fetch_valid),
    .fetch_req_i      (fetch_req),
    .fetch_ready_o    (fetch_ready),
    .rsp_valid_o      (rsp_valid),
    .rsp_o            (fetch_rsp),
    .mem_req_valid_o  (mem_req_valid),
    .mem_req_o        (mem_req),
    .mem_req_credit_i (mem_req_credit),
    .mem_rsp_valid_i  (mem_rsp_valid),
    .mem_rsp_i        (mem_rsp),
    .mem_rsp_credit_o (mem_rsp_credit)
  );

  tb_mem_model #(
    .Seed (Seed)
  ) mem_inst (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .req_valid_i  (mem_req_valid),
    .req_i        (mem_req),
    .req_credit_o (mem_req_credit),
    .rsp_credit_i (mem_rsp_credit),
    .rsp_valid_o  (mem_rsp_valid),
    .rsp_o        (mem_rsp),
    .req_count_o  (req_count)
  );

  always @(negedge clk) begin
    if (rst_n && rsp_valid) rsp_count <= rsp_count + 1;
  end

  ////////////////////////////////////////
  // Helpers

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Word-aligned byte address XOR C0DE0000, as the memory returns it
  function automatic word_t expected_word(input fetch_addr_t addr);
    return {addr[31:2], 2'b00} ^ 32'hC0DE_0000;
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR: %s is 0x%08h, expected 0x%08h", name, got, exp);
      $display(">>> FAIL");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  // Starts on a falling edge and counts cycles from the accepting edge to the response
  task automatic run_fetch(input fetch_addr_t addr, input logic flush,
                           output fetch_rsp_t got, output int unsigned cycles);
    fetch_valid     = 1'b1;
    fetch_req.addr  = addr;
    fetch_req.flush = flush;
    while (!fetch_ready) @(negedge clk);
    @(negedge clk);
    fetch_valid = 1'b0;
    fetch_req   = '0;
    cycles      = 0;
    while (!rsp_valid) begin
      @(negedge clk);
      cycles++;
    end
    got = fetch_rsp;
  endtask

  ////////////////////////////////////////
  // Stimulus

  initial begin : stimulus
    fetch_rsp_t  got;
    int unsigned cycles;
    int unsigned reqs_before;
    fetch_addr_t addr;
    logic [31:0] rnd;
    repeat (ResetCycles) @(negedge clk);
    check("fetch_ready_o", fetch_ready, 1'b0);
    check("rsp_valid_o", rsp_valid, 1'b0);
    check("mem_req_valid_o", mem_req_valid, 1'b0);
    check("mem_rsp_credit_o", mem_rsp_credit, 1'b0);
    rst_n = 1'b1;
    @(negedge clk);
    // Flush walk still running
    check("fetch_ready_o", fetch_ready, 1'b0);

    for (int i = 0; i < NumEntries; i++) begin
      reqs_before = req_count;
      run_fetch(stim[i].addr, stim[i].flush, got, cycles);
      check("rsp_o.fault", got.fault, stim[i].fault);
      if (!stim[i].fault) begin
        check("rsp_o.instr", got.instr, expected_word(stim[i].addr));
      end
      check("mem_req_o count", req_count - reqs_before, stim[i].req_delta);
      if (stim[i].latency != 0) begin
        check("rsp_valid_o latency", cycles, stim[i].latency);
      end
    end

    rnd = Seed;
    for (int n = 0; n < NumRandom; n++) begin
      rnd  = xorshift(rnd);
      addr = rnd & 32'h0000_7FFC;
      run_fetch(addr, 1'b0, got, cycles);
      check("rsp_o.fault", got.fault, 1'b0);
      check("rsp_o.instr", got.instr, expected_word(addr));
    end

    @(negedge clk);
    check("rsp_valid_o count", rsp_count, NumEntries + NumRandom);
    $display(">>> PASS");
    $finish;
  end

  initial begin : watchdog
    repeat (WatchdogCycles) @(posedge clk);
    $display("Watchdog expired, the cache stopped answering fetches");
    $display(">>> FAIL");
    $fatal(1, "Timeout");
  end

endmodule

// ==== tb_mem_model.sv ====
`timescale 1ns/1ps

module tb_mem_model #(
  parameter logic [31:0] Seed = 32'd28179
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 req_valid_i,
  input  icache_pkg::mem_req_t req_i,
  output logic                 req_credit_o,
  input  logic                 rsp_credit_i,
  output logic                 rsp_valid_o,
  output icache_pkg::mem_rsp_t rsp_o,
  output int unsigned          req_count_o
);
  import icache_pkg::*;

  // Byte address bit 27 marks the denied region
  localparam int unsigned DeniedBit = 27 - LineOffWidth;
  localparam int unsigned LastBeat  = 2 ** LineWordsWidth - 1;

  line_addr_t  line_q;
  word_off_t   beat_q;
  logic        active_q       = 1'b0;
  logic        credit_due_q   = 1'b0;
  logic [1:0]  gap_q          = 2'd0;
  int unsigned credits_q      = 0;
  logic [31:0] rnd_q          = Seed;
  logic        req_credit_q   = 1'b0;
  logic        rsp_valid_q    = 1'b0;
  mem_rsp_t    rsp_q          = '0;
  int unsigned count_q        = 0;

  assign req_credit_o = req_credit_q;
  assign rsp_valid_o  = rsp_valid_q;
  assign rsp_o        = rsp_q;
  assign req_count_o  = count_q;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic word_t word_at(input fetch_addr_t addr);
    return {addr[31:2], 2'b00} ^ 32'hC0DE_0000;
  endfunction

  ////////////////////////////////////////
  // Beat engine, driven on the falling edge

  always @(negedge clk_i) begin : drive
    logic send;
    if (!rst_ni) begin
      active_q     <= 1'b0;
      credit_due_q <= 1'b0;
      credits_q    <= 0;
      req_credit_q <= 1'b0;
      rsp_valid_q  <= 1'b0;
      rsp_q        <= '0;
      count_q      <= 0;
    end else begin
      // Only credits granted in earlier cycles may be spent
      send = active_q && gap_q == 2'd0 && credits_q != 0;
      rsp_valid_q  <= send;
      rsp_q        <= '0;
      req_credit_q <= credit_due_q;
      credit_due_q <= 1'b0;
      credits_q    <= credits_q - (send ? 1 : 0) + (rsp_credit_i ? 1 : 0);
      if (active_q && gap_q != 2'd0) begin
        gap_q <= gap_q - 2'd1;
      end
      if (send) begin
        rsp_q.data   <= word_at({line_q, beat_q, 2'b00});
        rsp_q.denied <= line_q[DeniedBit];
        rsp_q.last   <= beat_q == word_off_t'(LastBeat);
        beat_q       <= beat_q + 1'b1;
        gap_q        <= rnd_q[1:0];
        rnd_q        <= xorshift(rnd_q);
        if (beat_q == word_off_t'(LastBeat)) begin
          active_q     <= 1'b0;
          credit_due_q <= 1'b1;
        end
      end
      if (req_valid_i) begin
        line_q   <= req_i.line;
        beat_q   <= '0;
        active_q <= 1'b1;
        gap_q    <= rnd_q[1:0];
        rnd_q    <= xorshift(rnd_q);
        count_q  <= count_q + 1;
      end
    end
  end

endmodule

// ==== icache_top.sv ====
`timescale 1ns/1ps

module icache_top #(
  parameter int unsigned WaysWidth   = 2,
  parameter int unsigned SetsWidth   = 4,
  parameter int unsigned PhysAddrLen = 28,
  parameter int unsigned RspCredits  = 2
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   fetch_valid_i,
  input  icache_pkg::fetch_req_t fetch_req_i,
  output logic                   fetch_ready_o,
  output logic                   rsp_valid_o,
  output icache_pkg::fetch_rsp_t rsp_o,
  output logic                   mem_req_valid_o,
  output icache_pkg::mem_req_t   mem_req_o,
  input  logic                   mem_req_credit_i,
  input  logic                   mem_rsp_valid_i,
  input  icache_pkg::mem_rsp_t   mem_rsp_i,
  output logic                   mem_rsp_credit_o
);
  import icache_pkg::*;

  localparam int unsigned NumWays  = 2 ** WaysWidth;
  localparam int unsigned TagWidth = PhysAddrLen - SetsWidth - LineOffWidth;

  ////////////////////////////////////////
  // Array types

  typedef struct packed {
    logic [TagWidth-1:0] tag;
    logic                valid;
  } tag_t;

  typedef struct packed {
    logic [SetsWidth-1:0] set;
    logic [NumWays-1:0]   ways;
    tag_t                 entry;
  } tag_wr_t;

  typedef struct packed {
    logic                 en;
    logic [SetsWidth-1:0] set;
    word_off_t            off;
    logic [WaysWidth-1:0] way;
    word_t                word;
  } data_wr_t;

  lookup_stage_t             stage;
  logic                      rd_en;
  fetch_addr_t               rd_addr;
  tag_t  [NumWays-1:0]       rd_tags;
  word_t [NumWays-1:0]       rd_words;
  tag_wr_t                   refill_tag_wr;
  tag_wr_t                   flush_tag_wr;
  data_wr_t                  data_wr;
  logic                      miss_start;
  line_addr_t                miss_line;
  logic [WaysWidth-1:0]      miss_way;
  logic                      flush_start;
  logic                      replay;
  logic                      refill_busy;
  logic                      refill_done;
  logic                      refill_denied;
  logic                      flush_busy;
  logic                      flush_done;

  icache_lookup #(
    .PhysAddrLen (PhysAddrLen)
  ) lookup_inst (
    .clk_i,
    .rst_ni,
    .fetch_valid_i,
    .fetch_req_i,
    .fetch_ready_o,
    .busy_i    (refill_busy || flush_busy),
    .replay_i  (replay),
    .stage_o   (stage),
    .rd_en_o   (rd_en),
    .rd_addr_o (rd_addr)
  );

  icache_compare #(
    .WaysWidth   (WaysWidth),
    .SetsWidth   (SetsWidth),
    .PhysAddrLen (PhysAddrLen),
    .tag_t       (tag_t)
  ) compare_inst (
    .clk_i,
    .rst_ni,
    .stage_i         (stage),
    .rd_tags_i       (rd_tags),
    .rd_words_i      (rd_words),
    .refill_done_i   (refill_done),
    .refill_denied_i (refill_denied),
    .flush_done_i    (flush_done),
    .miss_start_o    (miss_start),
    .miss_line_o     (miss_line),
    .miss_way_o      (miss_way),
    .flush_start_o   (flush_start),
    .replay_o        (replay),
    .rsp_valid_o,
    .rsp_o
  );

  icache_refill #(
    .WaysWidth  (WaysWidth),
    .SetsWidth  (SetsWidth),
    .RspCredits (RspCredits),
    .tag_t      (tag_t),
    .tag_wr_t   (tag_wr_t),
    .data_wr_t  (data_wr_t)
  ) refill_inst (
    .clk_i,
    .rst_ni,
    .miss_start_i (miss_start),
    .miss_line_i  (miss_line),
    .miss_way_i   (miss_way),
    .mem_req_valid_o,
    .mem_req_o,
    .mem_req_credit_i,
    .mem_rsp_valid_i,
    .mem_rsp_i,
    .mem_rsp_credit_o,
    .data_wr_o    (data_wr),
    .tag_wr_o     (refill_tag_wr),
    .busy_o       (refill_busy),
    .done_o       (refill_done),
    .denied_o     (refill_denied)
  );

  icache_flush #(
    .SetsWidth (SetsWidth),
    .tag_wr_t  (tag_wr_t)
  ) flush_inst (
    .clk_i,
    .rst_ni,
    .start_i  (flush_start),
    .tag_wr_o (flush_tag_wr),
    .busy_o   (flush_busy),
    .done_o   (flush_done)
  );

  // Refill and flush never write in the same cycle, so the writes merge by OR
  icache_arrays #(
    .WaysWidth (WaysWidth),
    .SetsWidth (SetsWidth),
    .tag_t     (tag_t),
    .tag_wr_t  (tag_wr_t),
    .data_wr_t (data_wr_t)
  ) arrays_inst (
    .clk_i,
    .rd_en_i    (rd_en),
    .rd_addr_i  (rd_addr),
    .tag_wr_i   (refill_tag_wr | flush_tag_wr),
    .data_wr_i  (data_wr),
    .rd_tags_o  (rd_tags),
    .rd_words_o (rd_words)
  );

endmodule

// ==== icache_flush.sv ====
`timescale 1ns/1ps

module icache_flush #(
  parameter int unsigned SetsWidth = 4,
  parameter type         tag_wr_t  = logic
) (
  input  logic    clk_i,
  input  logic    rst_ni,
  input  logic    start_i,
  output tag_wr_t tag_wr_o,
  output logic    busy_o,
  output logic    done_o
);

  typedef enum logic {
    Walk,
    Idle
  } state_e;

  state_e               state_q;
  logic [SetsWidth-1:0] set_q;

  // One set per cycle, every way cleared to an invalid entry
  always_comb begin
    tag_wr_o = '0;
    done_o   = 1'b0;
    if (state_q == Walk) begin
      tag_wr_o.set  = set_q;
      tag_wr_o.ways = '1;
      done_o        = &set_q;
    end
  end

  assign busy_o = state_q == Walk || start_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Walk;
      set_q   <= '0;
    end else if (state_q == Walk) begin
      set_q <= set_q + 1'b1;
      if (&set_q) state_q <= Idle;
    end else if (start_i) begin
      state_q <= Walk;
    end
  end

endmodule

// ==== icache_refill.sv ====
`timescale 1ns/1ps

module icache_refill #(
  parameter int unsigned WaysWidth  = 2,
  parameter int unsigned SetsWidth  = 4,
  parameter int unsigned RspCredits = 2,
  parameter type         tag_t      = logic,
  parameter type         tag_wr_t   = logic,
  parameter type         data_wr_t  = logic
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   miss_start_i,
  input  icache_pkg::line_addr_t miss_line_i,
  input  logic [WaysWidth-1:0]   miss_way_i,
  output logic                   mem_req_valid_o,
  output icache_pkg::mem_req_t   mem_req_o,
  input  logic                   mem_req_credit_i,
  input  logic                   mem_rsp_valid_i,
  input  icache_pkg::mem_rsp_t   mem_rsp_i,
  output logic                   mem_rsp_credit_o,
  output data_wr_t               data_wr_o,
  output tag_wr_t                tag_wr_o,
  output logic                   busy_o,
  output logic                   done_o,
  output logic                   denied_o
);
  import icache_pkg::*;

  localparam int unsigned TagWidth   = $bits(tag_t) - 1;
  localparam int unsigned LineWords  = 2 ** LineWordsWidth;
  localparam int unsigned CredWidth  = $clog2(RspCredits + 1);
  localparam int unsigned SchedWidth = LineWordsWidth + 1;

  typedef enum logic [1:0] {
    Idle,
    Request,
    Beats
  } state_e;

  state_e                state_q, state_d;
  line_addr_t            line_q;
  logic [WaysWidth-1:0]  way_q;
  logic                  req_credit_q;
  // Credits still to pulse out, and credits the memory holds
  logic [CredWidth-1:0]  owed_q, owed_d;
  logic [CredWidth-1:0]  held_q, held_d;
  // Beats covered by credits so far
  logic [SchedWidth-1:0] sched_q, sched_d;
  word_off_t             beat_q;
  logic                  denied_q;
  logic                  beat;
  logic                  beat_denied;

  assign beat        = state_q == Beats && mem_rsp_valid_i;
  assign beat_denied = denied_q || mem_rsp_i.denied;

  assign mem_req_o.line   = line_q;
  assign mem_rsp_credit_o = owed_q != '0;
  assign busy_o           = state_q != Idle || miss_start_i;

  always_comb begin
    state_d         = state_q;
    owed_d          = owed_q;
    held_d          = held_q;
    sched_d         = sched_q;
    mem_req_valid_o = 1'b0;
    data_wr_o       = '0;
    tag_wr_o        = '0;
    done_o          = 1'b0;
    denied_o        = 1'b0;
    if (mem_rsp_credit_o) begin
      owed_d = owed_d - 1'b1;
      held_d = held_d + 1'b1;
    end
    unique case (state_q)
      Idle: begin
        if (miss_start_i) state_d = Request;
      end
      Request: begin
        // One line request per request credit
        if (req_credit_q) begin
          mem_req_valid_o = 1'b1;
          owed_d          = owed_d + CredWidth'(RspCredits);
          sched_d         = SchedWidth'(RspCredits);
          state_d         = Beats;
        end
      end
      Beats: begin
        if (beat) begin
          held_d = held_d - 1'b1;
          if (sched_q < SchedWidth'(LineWords)) begin
            owed_d  = owed_d + 1'b1;
            sched_d = sched_q + 1'b1;
          end
          if (!mem_rsp_i.denied) begin
            data_wr_o.en   = 1'b1;
            data_wr_o.set  = line_q[SetsWidth-1:0];
            data_wr_o.off  = beat_q;
            data_wr_o.way  = way_q;
            data_wr_o.word = mem_rsp_i.data;
          end
          // Tag goes valid only once the whole line is in
          if (mem_rsp_i.last) begin
            if (!beat_denied) begin
              tag_wr_o.set          = line_q[SetsWidth-1:0];
              tag_wr_o.ways[way_q]  = 1'b1;
              tag_wr_o.entry.tag    = line_q[SetsWidth +: TagWidth];
              tag_wr_o.entry.valid  = 1'b1;
            end
            done_o   = 1'b1;
            denied_o = beat_denied;
            state_d  = Idle;
          end
        end
      end
      default: state_d = Idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= Idle;
      req_credit_q <= 1'b1;
      owed_q       <= '0;
      held_q       <= '0;
      sched_q      <= '0;
      beat_q       <= '0;
      denied_q     <= 1'b0;
    end else begin
      state_q <= state_d;
      owed_q  <= owed_d;
      held_q  <= held_d;
      sched_q <= sched_d;
      if (mem_req_valid_o) begin
        req_credit_q <= 1'b0;
        beat_q       <= '0;
        denied_q     <= 1'b0;
      end else begin
        if (mem_req_credit_i) req_credit_q <= 1'b1;
        if (beat) begin
          beat_q   <= beat_q + 1'b1;
          denied_q <= beat_denied;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == Idle && miss_start_i) begin
      line_q <= miss_line_i;
      way_q  <= miss_way_i;
    end
  end

  // The memory side must keep to the credits handed out
  assert property (@(posedge clk_i) disable iff (!rst_ni) mem_rsp_valid_i |-> held_q != '0);
  assert property (@(posedge clk_i) disable iff (!rst_ni) held_q + owed_q <= RspCredits);

endmodule

// ==== icache_compare.sv ====
`timescale 1ns/1ps

module icache_compare #(
  parameter int unsigned WaysWidth   = 2,
  parameter int unsigned SetsWidth   = 4,
  parameter int unsigned PhysAddrLen = 28,
  parameter type         tag_t       = logic
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  icache_pkg::lookup_stage_t            stage_i,
  input  tag_t             [2**WaysWidth-1:0]  rd_tags_i,
  input  icache_pkg::word_t [2**WaysWidth-1:0] rd_words_i,
  input  logic                                 refill_done_i,
  input  logic                                 refill_denied_i,
  input  logic                                 flush_done_i,
  output logic                                 miss_start_o,
  output icache_pkg::line_addr_t               miss_line_o,
  output logic [WaysWidth-1:0]                 miss_way_o,
  output logic                                 flush_start_o,
  output logic                                 replay_o,
  output logic                                 rsp_valid_o,
  output icache_pkg::fetch_rsp_t               rsp_o
);
  import icache_pkg::*;

  localparam int unsigned NumWays = 2 ** WaysWidth;

  typedef enum logic [1:0] {
    Idle,
    Compare,
    WaitRefill,
    WaitFlush
  } state_e;

  state_e               state_q, state_d;
  lookup_stage_t        stage_q;
  logic [WaysWidth-1:0] fifo_q;
  logic [NumWays-1:0]   hit;
  logic [WaysWidth-1:0] hit_way;
  logic [WaysWidth-1:0] victim_way;
  logic                 any_invalid;
  logic                 range_ok;
  logic                 fifo_adv;
  logic                 rsp_valid_d;
  fetch_rsp_t           rsp_d;
  logic                 replay_d;

  assign range_ok = ~|stage_q.addr[FetchAddrWidth-1:PhysAddrLen];

  ////////////////////////////////////////
  // Hit and victim search

  // Walk downwards so the lowest matching way wins
  always_comb begin
    hit         = '0;
    hit_way     = '0;
    victim_way  = fifo_q;
    any_invalid = 1'b0;
    for (int w = NumWays - 1; w >= 0; w--) begin
      hit[w] = rd_tags_i[w].valid &&
               rd_tags_i[w].tag == stage_q.addr[PhysAddrLen-1:SetsWidth+LineOffWidth];
      if (hit[w]) begin
        hit_way = WaysWidth'(w);
      end
      if (!rd_tags_i[w].valid) begin
        victim_way  = WaysWidth'(w);
        any_invalid = 1'b1;
      end
    end
  end

  assign miss_line_o = stage_q.addr[FetchAddrWidth-1:LineOffWidth];
  assign miss_way_o  = victim_way;

  ////////////////////////////////////////
  // Control FSM

  always_comb begin
    state_d       = state_q;
    miss_start_o  = 1'b0;
    flush_start_o = 1'b0;
    fifo_adv      = 1'b0;
    rsp_valid_d   = 1'b0;
    rsp_d         = '0;
    replay_d      = 1'b0;
    unique case (state_q)
      Idle: begin
        if (stage_i.valid) state_d = Compare;
      end
      Compare: begin
        // A younger fetch may follow straight behind a hit or fault
        state_d = stage_i.valid ? Compare : Idle;
        if (!range_ok) begin
          rsp_valid_d = 1'b1;
          rsp_d.fault = 1'b1;
        end else if (stage_q.flush) begin
          flush_start_o = 1'b1;
          state_d       = WaitFlush;
        end else if (|hit) begin
          rsp_valid_d = 1'b1;
          rsp_d.instr = rd_words_i[hit_way];
        end else begin
          miss_start_o = 1'b1;
          fifo_adv     = !any_invalid;
          state_d      = WaitRefill;
        end
      end
      WaitRefill: begin
        if (refill_done_i) begin
          state_d = Idle;
          if (refill_denied_i) begin
            rsp_valid_d = 1'b1;
            rsp_d.fault = 1'b1;
          end else begin
            replay_d = 1'b1;
          end
        end
      end
      WaitFlush: begin
        if (flush_done_i) begin
          state_d  = Idle;
          replay_d = 1'b1;
        end
      end
      default: state_d = Idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= Idle;
      fifo_q      <= '0;
      rsp_valid_o <= 1'b0;
      replay_o    <= 1'b0;
    end else begin
      state_q     <= state_d;
      rsp_valid_o <= rsp_valid_d;
      replay_o    <= replay_d;
      if (fifo_adv) fifo_q <= fifo_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (stage_i.valid) stage_q <= stage_i;
    rsp_o <= rsp_d;
  end

  // Refill only fills a way when the line is absent from the set
  assert property (@(posedge clk_i) disable iff (!rst_ni) state_q == Compare |-> $onehot0(hit));

endmodule

// ==== icache_lookup.sv ====
`timescale 1ns/1ps

module icache_lookup #(
  parameter int unsigned PhysAddrLen = 28
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      fetch_valid_i,
  input  icache_pkg::fetch_req_t    fetch_req_i,
  output logic                      fetch_ready_o,
  input  logic                      busy_i,
  input  logic                      replay_i,
  output icache_pkg::lookup_stage_t stage_o,
  output logic                      rd_en_o,
  output icache_pkg::fetch_addr_t   rd_addr_o
);
  import icache_pkg::*;

  logic        pend_valid_q;
  fetch_req_t  pend_q;
  // Address of the fetch last handed to compare, kept for a replay
  fetch_addr_t last_addr_q;
  logic        in_range;
  logic        issue;
  logic        accept;

  assign in_range = ~|pend_q.addr[FetchAddrWidth-1:PhysAddrLen];

  // A replay takes the array port ahead of the waiting fetch
  assign issue         = pend_valid_q && !busy_i && !replay_i;
  assign fetch_ready_o = !busy_i && (!pend_valid_q || issue);
  assign accept        = fetch_valid_i && fetch_ready_o;

  ////////////////////////////////////////
  // Array read and stage handoff

  always_comb begin
    stage_o = '0;
    if (replay_i) begin
      // Replayed fetches never carry the flush bit again
      stage_o.valid = 1'b1;
      stage_o.addr  = last_addr_q;
    end else if (issue) begin
      stage_o.valid = 1'b1;
      stage_o.addr  = pend_q.addr;
      stage_o.flush = pend_q.flush;
    end
  end

  // Out of range fetches skip the read, compare faults them
  assign rd_en_o   = replay_i || (issue && in_range);
  assign rd_addr_o = replay_i ? last_addr_q : pend_q.addr;

  ////////////////////////////////////////
  // Fetch holding register

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pend_valid_q <= 1'b0;
    end else if (accept) begin
      pend_valid_q <= 1'b1;
    end else if (issue) begin
      pend_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      pend_q <= fetch_req_i;
    end
    if (issue) begin
      last_addr_q <= pend_q.addr;
    end
  end

  // A replay is only requested once refill and flush are idle again
  assert property (@(posedge clk_i) disable iff (!rst_ni) rd_en_o |-> !busy_i);

endmodule

// ==== icache_arrays.sv ====
`timescale 1ns/1ps

module icache_arrays #(
  parameter int unsigned WaysWidth = 2,
  parameter int unsigned SetsWidth = 4,
  parameter type         tag_t     = logic,
  parameter type         tag_wr_t  = logic,
  parameter type         data_wr_t = logic
) (
  input  logic                                 clk_i,
  input  logic                                 rd_en_i,
  input  icache_pkg::fetch_addr_t              rd_addr_i,
  input  tag_wr_t                              tag_wr_i,
  input  data_wr_t                             data_wr_i,
  output tag_t             [2**WaysWidth-1:0]  rd_tags_o,
  output icache_pkg::word_t [2**WaysWidth-1:0] rd_words_o
);
  import icache_pkg::*;

  localparam int unsigned NumWays  = 2 ** WaysWidth;
  localparam int unsigned NumSets  = 2 ** SetsWidth;
  localparam int unsigned NumWords = NumSets * (2 ** LineWordsWidth);

  logic [SetsWidth-1:0]                rd_set;
  logic [SetsWidth+LineWordsWidth-1:0] rd_idx;
  logic [SetsWidth+LineWordsWidth-1:0] wr_idx;

  assign rd_set = rd_addr_i[LineOffWidth +: SetsWidth];
  assign rd_idx = {rd_set, rd_addr_i[LineOffWidth-LineWordsWidth +: LineWordsWidth]};
  assign wr_idx = {data_wr_i.set, data_wr_i.off};

  for (genvar w = 0; w < NumWays; w++) begin : g_way
    tag_t  tag_mem  [NumSets];
    word_t word_mem [NumWords];
    tag_t  tag_rd_q;
    word_t word_rd_q;

    // Tag writes may hit several ways at once during a flush
    always_ff @(posedge clk_i) begin
      if (tag_wr_i.ways[w]) begin
        tag_mem[tag_wr_i.set] <= tag_wr_i.entry;
      end
      if (data_wr_i.en && data_wr_i.way == WaysWidth'(w)) begin
        word_mem[wr_idx] <= data_wr_i.word;
      end
      if (rd_en_i) begin
        tag_rd_q  <= tag_mem[rd_set];
        word_rd_q <= word_mem[rd_idx];
      end
    end

    assign rd_tags_o[w]  = tag_rd_q;
    assign rd_words_o[w] = word_rd_q;
  end

  // Lookup only reads once refill and flush have both gone quiet
  assert property (@(posedge clk_i) rd_en_i |-> !(|tag_wr_i.ways) && !data_wr_i.en);

endmodule

// ==== icache_pkg.sv ====
package icache_pkg;

  ////////////////////////////////////////
  // Fixed widths

  localparam int unsigned FetchAddrWidth = 32;
  localparam int unsigned WordWidth      = 32;
  // A line holds 2 ** LineWordsWidth words
  localparam int unsigned LineWordsWidth = 3;
  // Byte offset bits inside a line
  localparam int unsigned LineOffWidth   = LineWordsWidth + $clog2(WordWidth / 8);

  typedef logic [FetchAddrWidth-1:0]              fetch_addr_t;
  typedef logic [WordWidth-1:0]                   word_t;
  typedef logic [LineWordsWidth-1:0]              word_off_t;
  typedef logic [FetchAddrWidth-LineOffWidth-1:0] line_addr_t;

  ////////////////////////////////////////
  // Fetch side

  typedef struct packed {
    fetch_addr_t addr;
    logic        flush;
  } fetch_req_t;

  typedef struct packed {
    word_t instr;
    logic  fault;
  } fetch_rsp_t;

  // Handed from lookup to compare with the array read
  typedef struct packed {
    logic        valid;
    fetch_addr_t addr;
    logic        flush;
  } lookup_stage_t;

  ////////////////////////////////////////
  // Memory side

  typedef struct packed {
    line_addr_t line;
  } mem_req_t;

  typedef struct packed {
    word_t data;
    logic  denied;
    logic  last;
  } mem_rsp_t;

endpackage
